// File: files.f
verilog/lc_core_pkg.sv
verilog/lc_isa_pkg.sv
verilog/lc_dispatch.sv
verilog/lc_issue_queue.sv
verilog/lc_regfile_sb.sv
verilog/lc_execute.sv
verilog/lc_issue_top.sv
testbench/lc_checker.sv
testbench/tb_lc_issue.sv

// File: run.sh
#!/bin/sh
# compile and run the issue path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lc_issue \
	-f files.f -o sim_lc_issue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_lc_issue)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

// File: testbench/lc_checker.sv
/*
 * result checker for the issue path
 * program-order register model, in-flight record table,
 * writeback matching and missing writeback report
 */

`timescale 1ns/1ps
`default_nettype none

module lc_checker
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
#(
	parameter int xlen = default_xlen
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  logic            in_ready,
	input  lc_op_e          in_op,
	input  reg_idx_t        in_rd,
	input  reg_idx_t        in_rs1,
	input  lc_opnd2_u       in_opnd2,
	input  logic [127:0]    test_name,
	input  logic            exp_given,
	input  logic [xlen-1:0] exp_value,
	input  logic            wb_valid,
	input  reg_idx_t        wb_rd,
	input  logic [xlen-1:0] wb_data,
	input  logic            report_req,
	output int              error_count,
	output int              pending_count
);

	localparam int max_records = 256;

	logic [127:0] rec_name [max_records];
	reg_idx_t rec_rd [max_records];
	logic [xlen-1:0] rec_exp [max_records];
	logic rec_done [max_records];
	logic [xlen-1:0] model_regs [nregs];
	int n_rec;
	logic reported;

	// drop the zero padding in front of a short name
	function automatic string trim_name(input logic [127:0] v);
		string s;
		int k;
		s = "";
		for (k = 15; k >= 0; k--) begin
			if (v[k*8 +: 8] != 8'h00)
				s = $sformatf("%s%c", s, v[k*8 +: 8]);
		end
		return s;
	endfunction

	// architectural result in program order
	function automatic logic [xlen-1:0] model_result(input lc_op_e op, input reg_idx_t rs1,
		input lc_opnd2_u opnd2);
		logic imm_form;
		logic unsigned_cmp;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic lt;
		imm_form = (op == op_slti) || (op == op_sltiu) || (op == op_xori) ||
			(op == op_ori) || (op == op_andi);
		unsigned_cmp = (op == op_sltiu) || (op == op_sltu);
		a = model_regs[rs1];
		if (imm_form)
			b = {{(xlen-12){opnd2.imm[11]}}, opnd2.imm};
		else
			b = model_regs[opnd2.rs2[4:0]];
		if (unsigned_cmp)
			lt = a < b;
		else
			lt = $signed(a) < $signed(b);
		case (op)
			op_slti, op_sltiu, op_slt, op_sltu: return lt ? 1 : 0;
			op_xori, op_xor: return a ^ b;
			op_ori, op_or: return a | b;
			default: return a & b;
		endcase
	endfunction

	// everything is stable half a cycle after the driving edge
	always @(negedge clk) begin
		int i;
		int hit;
		logic [xlen-1:0] expv;
		if (!rst_n) begin
			n_rec = 0;
			pending_count = 0;
			reported = 1'b0;
			for (i = 0; i < nregs; i++)
				model_regs[i] = '0;
		end else begin
			if (wb_valid) begin
				hit = -1;
				// WAW stalls leave one in-flight writer per rd
				for (i = 0; i < n_rec; i++) begin
					if (hit < 0 && !rec_done[i] && rec_rd[i] == wb_rd)
						hit = i;
				end
				if (hit < 0) begin
					error_count++;
					$display("writeback to x%0d arrived with no instruction in flight", wb_rd);
				end else begin
					rec_done[hit] = 1'b1;
					pending_count--;
					if (wb_data !== rec_exp[hit]) begin
						error_count++;
						$display("MISMATCH %s: expected %h, actual %h",
							trim_name(rec_name[hit]), rec_exp[hit], wb_data);
					end
				end
			end
			if (in_valid && in_ready) begin
				if (n_rec < max_records) begin
					expv = exp_given ? exp_value : model_result(in_op, in_rs1, in_opnd2);
					rec_name[n_rec] = test_name;
					rec_rd[n_rec] = in_rd;
					rec_exp[n_rec] = expv;
					rec_done[n_rec] = 1'b0;
					n_rec++;
					pending_count++;
					if (in_rd != '0)
						model_regs[in_rd] = expv;
				end else begin
					error_count++;
					$display("more instructions accepted than the checker can track");
				end
			end
			if (report_req && !reported) begin
				reported = 1'b1;
				for (i = 0; i < n_rec; i++) begin
					if (!rec_done[i]) begin
						error_count++;
						$display("no writeback was seen for %s to x%0d",
							trim_name(rec_name[i]), rec_rd[i]);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_lc_issue.sv
/*
 * testbench for the logic/compare issue path
 * clock and reset, directed table, LCG random burst, DUT and checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_lc_issue
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
();

	localparam int xlen = 64;
	localparam int queue_depth = 4;
	localparam int nrows = 23;
	localparam int burst_len = 40;
	localparam int ready_limit = 200;
	localparam int drain_limit = 500;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	lc_op_e in_op;
	reg_idx_t in_rd;
	reg_idx_t in_rs1;
	lc_opnd2_u in_opnd2;
	logic wb_valid;
	reg_idx_t wb_rd;
	logic [xlen-1:0] wb_data;
	logic [127:0] test_name;
	logic exp_given;
	logic [xlen-1:0] exp_value;
	logic report_req;
	int checker_errors;
	int pending_count;
	int timeout_count;
	int stall_cycles;

	logic [127:0] row_name [nrows];
	lc_op_e row_op [nrows];
	reg_idx_t row_rd [nrows];
	reg_idx_t row_rs1 [nrows];
	logic [11:0] row_opnd2 [nrows];
	logic [xlen-1:0] row_exp [nrows];

	lc_issue_top #(
		.xlen        (xlen),
		.queue_depth (queue_depth)
	) i_lc_issue_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_op    (in_op),
		.in_rd    (in_rd),
		.in_rs1   (in_rs1),
		.in_opnd2 (in_opnd2),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	lc_checker #(
		.xlen (xlen)
	) i_lc_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_op         (in_op),
		.in_rd         (in_rd),
		.in_rs1        (in_rs1),
		.in_opnd2      (in_opnd2),
		.test_name     (test_name),
		.exp_given     (exp_given),
		.exp_value     (exp_value),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.report_req    (report_req),
		.error_count   (checker_errors),
		.pending_count (pending_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic set_row(input int idx, input logic [127:0] name, input lc_op_e op,
		input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] opnd2,
		input logic [xlen-1:0] expv);
		row_name[idx] = name;
		row_op[idx] = op;
		row_rd[idx] = rd;
		row_rs1[idx] = rs1;
		row_opnd2[idx] = opnd2;
		row_exp[idx] = expv;
	endtask

	// expected values follow program order, register forms hold the rs2 index
	task automatic load_table();
		set_row(0, "ori_pos", op_ori, 5'd1, 5'd0, 12'h123, 64'h123);
		set_row(1, "ori_neg", op_ori, 5'd2, 5'd0, 12'h800, 64'hffff_ffff_ffff_f800);
		set_row(2, "xori_neg", op_xori, 5'd3, 5'd0, 12'hfff, 64'hffff_ffff_ffff_ffff);
		set_row(3, "andi_mask", op_andi, 5'd4, 5'd3, 12'h0f0, 64'h0f0);
		set_row(4, "andi_sext", op_andi, 5'd5, 5'd2, 12'hfff, 64'hffff_ffff_ffff_f800);
		set_row(5, "slt_neg", op_slt, 5'd6, 5'd2, 12'd1, 64'h1);
		set_row(6, "sltu_neg", op_sltu, 5'd7, 5'd2, 12'd1, 64'h0);
		set_row(7, "slti_neg", op_slti, 5'd8, 5'd3, 12'h000, 64'h1);
		set_row(8, "sltiu_neg", op_sltiu, 5'd9, 5'd3, 12'h000, 64'h0);
		set_row(9, "sltiu_m1", op_sltiu, 5'd10, 5'd1, 12'hfff, 64'h1);
		set_row(10, "slti_m1", op_slti, 5'd11, 5'd1, 12'hfff, 64'h0);
		set_row(11, "chain_xor", op_xor, 5'd12, 5'd1, 12'd4, 64'h1d3);
		set_row(12, "chain_or", op_or, 5'd13, 5'd12, 12'd2, 64'hffff_ffff_ffff_f9d3);
		set_row(13, "chain_and", op_and, 5'd14, 5'd13, 12'd1, 64'h103);
		set_row(14, "chain_slt", op_slt, 5'd15, 5'd14, 12'd13, 64'h0);
		set_row(15, "chain_sltu", op_sltu, 5'd16, 5'd15, 12'd14, 64'h1);
		set_row(16, "chain_xor2", op_xor, 5'd17, 5'd16, 12'd3, 64'hffff_ffff_ffff_fffe);
		set_row(17, "x0_dest", op_ori, 5'd0, 5'd1, 12'h555, 64'h577);
		set_row(18, "x0_read", op_or, 5'd18, 5'd0, 12'd4, 64'h0f0);
		set_row(19, "x0_xori", op_xori, 5'd19, 5'd0, 12'h0aa, 64'h0aa);
		set_row(20, "waw_reuse", op_xori, 5'd1, 5'd1, 12'h0ff, 64'h1dc);
		set_row(21, "raw_after", op_and, 5'd20, 5'd1, 12'd3, 64'h1dc);
		set_row(22, "x0_src2", op_xor, 5'd21, 5'd19, 12'd0, 64'h0aa);
	endtask

	// called 1 ns after a rising edge, returns at the same point
	task automatic send_instr(input logic [127:0] name, input lc_op_e op, input reg_idx_t rd,
		input reg_idx_t rs1, input logic [11:0] opnd2, input logic given,
		input logic [xlen-1:0] expv);
		int waited;
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		in_valid = 1'b1;
		in_op = op;
		in_rd = rd;
		in_rs1 = rs1;
		in_opnd2 = opnd2;
		test_name = name;
		exp_given = given;
		exp_value = expv;
		while (!accepted && waited < ready_limit) begin
			@(negedge clk);
			accepted = in_ready;
			if (!in_ready)
				stall_cycles++;
			@(posedge clk);
			#1;
			waited++;
		end
		in_valid = 1'b0;
		if (!accepted) begin
			timeout_count++;
			$display("timeout: in_ready stayed low for %0d cycles", ready_limit);
		end
	endtask

	initial begin
		int i;
		int waited;
		int tb_errors;
		int total_errors;
		logic [31:0] seed;
		lc_op_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		logic [11:0] opnd2;
		tb_errors = 0;
		timeout_count = 0;
		stall_cycles = 0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = op_slti;
		in_rd = '0;
		in_rs1 = '0;
		in_opnd2 = '0;
		test_name = '0;
		exp_given = 1'b0;
		exp_value = '0;
		report_req = 1'b0;
		load_table();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		if (!in_ready) begin
			tb_errors++;
			$display("in_ready is low right after reset");
		end
		@(posedge clk);
		#1;
		for (i = 0; i < nrows; i++) begin
			if (timeout_count == 0)
				send_instr(row_name[i], row_op[i], row_rd[i], row_rs1[i], row_opnd2[i],
					1'b1, row_exp[i]);
		end
		// burst on x1..x7 keeps WAW and WAR stalls frequent
		seed = 32'hce35_5ba6;
		stall_cycles = 0;
		for (i = 0; i < burst_len; i++) begin
			if (timeout_count == 0) begin
				seed = lcg_next(seed);
				op = lc_op_e'(4'(seed[31:16] % 10));
				seed = lcg_next(seed);
				rd = 5'(1 + seed[31:16] % 7);
				seed = lcg_next(seed);
				rs1 = 5'(seed[31:16] % 8);
				seed = lcg_next(seed);
				if (op inside {op_slt, op_sltu, op_xor, op_or, op_and})
					opnd2 = {9'd0, seed[18:16]};
				else
					opnd2 = seed[27:16];
				send_instr("burst", op, rd, rs1, opnd2, 1'b0, '0);
			end
		end
		if (timeout_count == 0 && stall_cycles == 0) begin
			tb_errors++;
			$display("dispatch never stalled during the random burst");
		end
		waited = 0;
		while (pending_count != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
		if (pending_count != 0) begin
			timeout_count++;
			$display("timeout: %0d writebacks still outstanding", pending_count);
		end
		#1;
		report_req = 1'b1;
		@(negedge clk);
		@(posedge clk);
		total_errors = tb_errors + checker_errors;
		$display("errors: %0d, timeouts: %0d", total_errors, timeout_count);
		if (total_errors == 0 && timeout_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/lc_core_pkg.sv
/*
 * core-wide defaults for the logic/compare path
 * datapath width default, register count, register index type
 */

`default_nettype none

package lc_core_pkg;

	// default only, the top level sets the real width
	parameter int default_xlen = 64;

	// architectural registers, x0 included
	localparam int nregs = 32;

	typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

// File: verilog/lc_dispatch.sv
/*
 * dispatch stage: one-entry input register,
 * WAW/WAR hazard stall, scoreboard busy marking
 */

`timescale 1ns/1ps
`default_nettype none

module lc_dispatch
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  lc_op_e           in_op,
	input  reg_idx_t         in_rd,
	input  reg_idx_t         in_rs1,
	input  lc_opnd2_u        in_opnd2,
	input  logic [nregs-1:0] busy_mask,
	input  logic [nregs-1:0] src_pending,
	output logic             dq_valid,
	input  logic             dq_ready,
	output lc_instr_t        dq_instr,
	output logic             set_busy,
	output reg_idx_t         set_idx
);

	logic valid_q;
	lc_instr_t instr_q;
	logic stall;
	logic war_in;
	logic leave;

	// WAW on a busy rd, WAR on a source still waiting in the queue
	assign stall = (instr_q.rd != '0) &&
		(busy_mask[instr_q.rd] || src_pending[instr_q.rd]);

	// incoming rd overwrites a source of the held instruction
	assign war_in = valid_q && (in_rd != '0) &&
		((in_rd == instr_q.rs1) ||
		(!uses_imm(instr_q.op) && (in_rd == instr_q.opnd2.rs2[4:0])));

	assign dq_valid = valid_q && !stall;
	assign dq_instr = instr_q;
	assign leave = dq_valid && dq_ready;
	assign in_ready = !valid_q || (leave && !war_in);

	assign set_busy = leave && (instr_q.rd != '0);
	assign set_idx = instr_q.rd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_valid && in_ready) begin
			valid_q <= 1'b1;
		end else if (leave) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			instr_q <= '{op: in_op, rd: in_rd, rs1: in_rs1, opnd2: in_opnd2};
		end
	end

	// marked destination shows up busy in the scoreboard next cycle
	a_set_busy_seen: assert property (@(posedge clk) disable iff (!rst_n)
		set_busy |=> busy_mask[$past(set_idx)]);

	// x0 is never marked busy
	a_x0_never_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!busy_mask[0]);

endmodule

`default_nettype wire

// File: verilog/lc_execute.sv
/*
 * execute stage: operand select, signed/unsigned compare,
 * bitwise logic, registered writeback outputs
 */

`timescale 1ns/1ps
`default_nettype none

module lc_execute
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
#(
	parameter int xlen = default_xlen
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            iss_valid,
	input  lc_instr_t       iss_instr,
	output reg_idx_t        rd_idx1,
	output reg_idx_t        rd_idx2,
	input  logic [xlen-1:0] rd_data1,
	input  logic [xlen-1:0] rd_data2,
	output logic            wb_valid,
	output reg_idx_t        wb_rd,
	output logic [xlen-1:0] wb_data
);

	logic [xlen-1:0] imm_ext;
	logic [xlen-1:0] op2;
	logic [xlen-1:0] result;
	logic less;

	assign rd_idx1 = iss_instr.rs1;
	assign rd_idx2 = iss_instr.opnd2.rs2[4:0];

	assign imm_ext = {{(xlen-12){iss_instr.opnd2.imm[11]}}, iss_instr.opnd2.imm};
	assign op2 = uses_imm(iss_instr.op) ? imm_ext : rd_data2;

	assign less = is_unsigned(iss_instr.op) ? (rd_data1 < op2) :
		($signed(rd_data1) < $signed(op2));

	always_comb begin
		case (iss_instr.op)
			op_slti, op_sltiu, op_slt, op_sltu: result = {{(xlen-1){1'b0}}, less};
			op_xori, op_xor: result = rd_data1 ^ op2;
			op_ori, op_or: result = rd_data1 | op2;
			default: result = rd_data1 & op2;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= iss_valid;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= iss_instr.rd;
		wb_data <= result;
	end

endmodule

`default_nettype wire

// File: verilog/lc_isa_pkg.sv
/*
 * logic/compare instruction set view
 * operation enum, second operand union, instruction word,
 * immediate and unsigned decode helpers
 */

`default_nettype none

package lc_isa_pkg;
	import lc_core_pkg::*;

	typedef enum logic [3:0] {
		op_slti,
		op_sltiu,
		op_slt,
		op_sltu,
		op_xori,
		op_xor,
		op_ori,
		op_or,
		op_andi,
		op_and
	} lc_op_e;

	// imm for i-forms, rs2 index in bits 4:0 for register forms
	typedef union packed {
		logic [11:0] imm;
		logic [11:0] rs2;
	} lc_opnd2_u;

	typedef struct packed {
		lc_op_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		lc_opnd2_u opnd2;
	} lc_instr_t;

	function automatic logic uses_imm(lc_op_e op);
		return op inside {op_slti, op_sltiu, op_xori, op_ori, op_andi};
	endfunction

	function automatic logic is_unsigned(lc_op_e op);
		return op inside {op_sltiu, op_sltu};
	endfunction

endpackage

`default_nettype wire

// File: verilog/lc_issue_queue.sv
/*
 * issue queue: entry slots with valid bits,
 * source readiness from the scoreboard, lowest-index ready issue,
 * pending source mask back to dispatch
 */

`timescale 1ns/1ps
`default_nettype none

module lc_issue_queue
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
#(
	parameter int xlen = default_xlen,
	parameter int queue_depth = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             dq_valid,
	output logic             dq_ready,
	input  lc_instr_t        dq_instr,
	input  logic [nregs-1:0] busy_mask,
	output logic [nregs-1:0] src_pending,
	output logic             iss_valid,
	output lc_instr_t        iss_instr
);

	localparam int slot_w = $clog2(queue_depth);

	// 12-bit immediate has to fit the datapath
	if (queue_depth < 2 || xlen < 12) begin : g_param_check
		$error("lc_issue_queue: unsupported queue_depth or xlen");
	end

	lc_instr_t slot_q [queue_depth];
	logic [queue_depth-1:0] valid_q;
	logic [queue_depth-1:0] ready_vec;
	logic [queue_depth-1:0] issue_free;
	logic [queue_depth-1:0] avail;
	logic [slot_w-1:0] iss_slot;
	logic [slot_w-1:0] alloc_slot;
	logic push;

	for (genvar i = 0; i < queue_depth; i++) begin : g_ready
		reg_idx_t rs2_idx;
		logic rs1_ok;
		logic rs2_ok;

		assign rs2_idx = slot_q[i].opnd2.rs2[4:0];
		// own rd was free at dispatch and nobody else may claim it meanwhile
		assign rs1_ok = (slot_q[i].rs1 == slot_q[i].rd) || !busy_mask[slot_q[i].rs1];
		assign rs2_ok = uses_imm(slot_q[i].op) || (rs2_idx == slot_q[i].rd) ||
			!busy_mask[rs2_idx];
		assign ready_vec[i] = valid_q[i] && rs1_ok && rs2_ok;
	end

	// lowest index wins
	always_comb begin
		iss_valid = 1'b0;
		iss_slot = '0;
		for (int i = queue_depth - 1; i >= 0; i--) begin
			if (ready_vec[i]) begin
				iss_valid = 1'b1;
				iss_slot = i[slot_w-1:0];
			end
		end
	end

	assign iss_instr = slot_q[iss_slot];

	// a slot issuing this cycle may be refilled at once
	assign issue_free = iss_valid ? ({{(queue_depth-1){1'b0}}, 1'b1} << iss_slot) : '0;
	assign avail = ~valid_q | issue_free;

	always_comb begin
		alloc_slot = '0;
		for (int i = queue_depth - 1; i >= 0; i--) begin
			if (avail[i]) begin
				alloc_slot = i[slot_w-1:0];
			end
		end
	end

	assign dq_ready = !(&valid_q) || iss_valid;
	assign push = dq_valid && dq_ready;

	always_comb begin
		src_pending = '0;
		for (int i = 0; i < queue_depth; i++) begin
			if (valid_q[i]) begin
				src_pending[slot_q[i].rs1] = 1'b1;
				if (!uses_imm(slot_q[i].op))
					src_pending[slot_q[i].opnd2.rs2[4:0]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			if (iss_valid)
				valid_q[iss_slot] <= 1'b0;
			if (push)
				valid_q[alloc_slot] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			slot_q[alloc_slot] <= dq_instr;
		end
	end

	// an arrival never lands on an entry that is still held
	a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !valid_q[alloc_slot] || (iss_valid && (iss_slot == alloc_slot)));

	// arrivals never write a register a waiting entry still reads
	a_no_war_entry: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (dq_instr.rd == '0) || !src_pending[dq_instr.rd]);

endmodule

`default_nettype wire

// File: verilog/lc_issue_top.sv
/*
 * logic/compare issue path top level
 * dispatch, issue queue, execute and register file
 */

`timescale 1ns/1ps
`default_nettype none

module lc_issue_top
	import lc_core_pkg::*;
	import lc_isa_pkg::*;
#(
	parameter int xlen = default_xlen,
	parameter int queue_depth = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  lc_op_e          in_op,
	input  reg_idx_t        in_rd,
	input  reg_idx_t        in_rs1,
	input  lc_opnd2_u       in_opnd2,
	output logic            wb_valid,
	output reg_idx_t        wb_rd,
	output logic [xlen-1:0] wb_data
);

	logic dq_valid;
	logic dq_ready;
	lc_instr_t dq_instr;
	logic [nregs-1:0] busy_mask;
	logic [nregs-1:0] src_pending;
	logic set_busy;
	reg_idx_t set_idx;
	logic iss_valid;
	lc_instr_t iss_instr;
	reg_idx_t rd_idx1;
	reg_idx_t rd_idx2;
	logic [xlen-1:0] rd_data1;
	logic [xlen-1:0] rd_data2;

	lc_dispatch i_lc_dispatch (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_op       (in_op),
		.in_rd       (in_rd),
		.in_rs1      (in_rs1),
		.in_opnd2    (in_opnd2),
		.busy_mask   (busy_mask),
		.src_pending (src_pending),
		.dq_valid    (dq_valid),
		.dq_ready    (dq_ready),
		.dq_instr    (dq_instr),
		.set_busy    (set_busy),
		.set_idx     (set_idx)
	);

	lc_issue_queue #(
		.xlen        (xlen),
		.queue_depth (queue_depth)
	) i_lc_issue_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.dq_valid    (dq_valid),
		.dq_ready    (dq_ready),
		.dq_instr    (dq_instr),
		.busy_mask   (busy_mask),
		.src_pending (src_pending),
		.iss_valid   (iss_valid),
		.iss_instr   (iss_instr)
	);

	lc_execute #(
		.xlen (xlen)
	) i_lc_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.iss_valid (iss_valid),
		.iss_instr (iss_instr),
		.rd_idx1   (rd_idx1),
		.rd_idx2   (rd_idx2),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	lc_regfile_sb #(
		.xlen (xlen)
	) i_lc_regfile_sb (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx1   (rd_idx1),
		.rd_idx2   (rd_idx2),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.set_busy  (set_busy),
		.set_idx   (set_idx),
		.busy_mask (busy_mask)
	);

endmodule

`default_nettype wire

// File: verilog/lc_regfile_sb.sv
/*
 * integer register file, x0 hardwired to zero,
 * scoreboard busy bits set at dispatch and cleared at writeback
 */

`timescale 1ns/1ps
`default_nettype none

module lc_regfile_sb
	import lc_core_pkg::*;
#(
	parameter int xlen = default_xlen
) (
	input  logic             clk,
	input  logic             rst_n,
	input  reg_idx_t         rd_idx1,
	input  reg_idx_t         rd_idx2,
	output logic [xlen-1:0]  rd_data1,
	output logic [xlen-1:0]  rd_data2,
	input  logic             wb_valid,
	input  reg_idx_t         wb_rd,
	input  logic [xlen-1:0]  wb_data,
	input  logic             set_busy,
	input  reg_idx_t         set_idx,
	output logic [nregs-1:0] busy_mask
);

	// entry 0 is cleared at reset and never written
	logic [xlen-1:0] regs_q [nregs];
	logic [nregs-1:0] busy_q;

	assign rd_data1 = regs_q[rd_idx1];
	assign rd_data2 = regs_q[rd_idx2];
	assign busy_mask = busy_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < nregs; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_valid && (wb_rd != '0)) begin
			regs_q[wb_rd] <= wb_data;
		end
	end

	// set is last so it wins over a same-cycle clear
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= '0;
		end else begin
			if (wb_valid)
				busy_q[wb_rd] <= 1'b0;
			if (set_busy)
				busy_q[set_idx] <= 1'b1;
		end
	end

	a_wb_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_rd == '0) || busy_q[wb_rd]);

endmodule

`default_nettype wire
